//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// ------------------------------
	// fetch address split
	// ------------------------------
	localparam int addr_w   = 32;
	localparam int off_w    = 4;                 // byte offset inside a line
	localparam int word_lsb = 2;                 // instructions are word aligned
	localparam int word_w   = off_w - word_lsb;  // 2
	localparam int set_lsb  = off_w;
	localparam int set_w    = 6;                 // addr[9:4]
	localparam int tag_lsb  = set_lsb + set_w;
	localparam int tag_w    = addr_w - tag_lsb;  // addr[31:10], 22 bits

	// ------------------------------
	// cache geometry
	// ------------------------------
	localparam int ways   = 4;
	localparam int sets   = 1 << set_w;          // 64
	localparam int words  = 1 << word_w;         // instructions per line
	localparam int inst_w = 32;
	localparam int line_w = words * inst_w;      // 128

endpackage

`default_nettype wire

//--- design/icache_rsp_if.sv
`timescale 1ns/1ps
`default_nettype none

// registered lookup result, one response in flight
interface icache_rsp_if (
	input wire clk,
	input wire rst
);
	logic [icache_pkg::ways-1:0]   hit_way_q;    // one-hot way, zero after a miss
	logic [icache_pkg::line_w-1:0] fill_line_q;  // line returned by memory on a miss
	logic [icache_pkg::word_w-1:0] word_q;       // word of the accepted address
	logic                          pending_q;    // response owed to the fetch stage

	modport lookup_side (
		output hit_way_q,
		output fill_line_q,
		output word_q,
		output pending_q
	);

	modport out_side (
		input clk,
		input rst,
		input hit_way_q,
		input fill_line_q,
		input word_q,
		input pending_q
	);
endinterface

`default_nettype wire

//--- design/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

// one data way of the cache
// single port, one access per enabled edge
module line_ram (
	input  wire                            clk,
	input  wire                            en,
	input  wire                            we,
	input  wire  [icache_pkg::set_w-1:0]   idx,
	input  wire  [icache_pkg::line_w-1:0]  wdata,
	output logic [icache_pkg::line_w-1:0]  rdata
);

	logic [icache_pkg::line_w-1:0] mem [icache_pkg::sets];

	// ------------------------------
	// write or read, never both
	// ------------------------------
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[idx] <= wdata;    // refill, rdata keeps old line
			end else begin
				rdata <= mem[idx];
			end
		end
		// not enabled: rdata holds, this is what keeps inst steady on a stall
	end

endmodule

`default_nettype wire

//--- design/icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
	input  wire                                   clk,
	input  wire                                   rst,
	input  wire  [icache_pkg::addr_w-1:0]         fetch_addr,
	input  wire                                   fetch_valid,
	input  wire                                   flush,
	input  wire                                   out_ready,
	output logic                                  mem_req,
	output logic [icache_pkg::addr_w-1:0]         mem_addr,
	input  wire  [icache_pkg::line_w-1:0]         mem_line,
	icache_rsp_if.lookup_side                     rsp,
	output logic [icache_pkg::ways-1:0][icache_pkg::line_w-1:0] way_data
);

	logic [icache_pkg::tag_w-1:0]  tag;
	logic [icache_pkg::set_w-1:0]  set_idx;
	logic [icache_pkg::word_w-1:0] word;

	logic [icache_pkg::ways-1:0] hit;
	logic [icache_pkg::ways-1:0] rotor;      // one-hot victim pointer
	logic [icache_pkg::ways-1:0] ram_en;
	logic                        advance;    // pipeline steps at this edge
	logic                        accept;
	logic                        miss;

	// ------------------------------
	// address fields, accept, miss
	// ------------------------------
	assign tag     = fetch_addr[icache_pkg::tag_lsb +: icache_pkg::tag_w];
	assign set_idx = fetch_addr[icache_pkg::set_lsb +: icache_pkg::set_w];
	assign word    = fetch_addr[icache_pkg::word_lsb +: icache_pkg::word_w];

	assign advance = out_ready && !flush && !rst;
	assign accept  = advance && fetch_valid;      // a flush cycle never accepts
	assign miss    = accept && (hit == '0);

	// memory answers combinationally in this same cycle
	assign mem_req  = miss;
	assign mem_addr = {fetch_addr[icache_pkg::addr_w-1:icache_pkg::off_w],
		{icache_pkg::off_w{1'b0}}};

	// ------------------------------
	// per way: tags, valid bits, data
	// ------------------------------
	for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
		logic [icache_pkg::tag_w-1:0] tag_arr [icache_pkg::sets];
		logic [icache_pkg::sets-1:0]  vld;
		logic                         fill;

		assign fill      = miss && rotor[w];    // this way is the victim
		assign hit[w]    = vld[set_idx] && (tag_arr[set_idx] == tag);
		assign ram_en[w] = accept && (hit[w] || fill);

		always_ff @(posedge clk) begin
			if (rst) begin
				vld <= '0;
			end else if (fill) begin
				vld[set_idx] <= 1'b1;
			end
		end

		always_ff @(posedge clk) begin
			if (fill) begin
				tag_arr[set_idx] <= tag;
			end
		end

		// hit ways read, the victim way takes the refill
		line_ram u_ram (
			.clk   (clk),
			.en    (ram_en[w]),
			.we    (miss),
			.idx   (set_idx),
			.wdata (mem_line),
			.rdata (way_data[w])
		);
	end

	// ------------------------------
	// response registers and rotor
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rotor         <= {{(icache_pkg::ways-1){1'b0}}, 1'b1};
			rsp.pending_q <= 1'b0;
			rsp.hit_way_q <= '0;
		end else if (out_ready) begin
			rsp.pending_q <= accept;    // flush lands here as zero
			rsp.hit_way_q <= hit & {icache_pkg::ways{accept}};
			if (!flush) begin
				rotor <= {rotor[icache_pkg::ways-2:0], rotor[icache_pkg::ways-1]};
			end
		end
	end

	// payload only, qualified by pending_q downstream
	always_ff @(posedge clk) begin
		if (miss) begin
			rsp.fill_line_q <= mem_line;    // bypass copy of the refill
		end
		if (accept) begin
			rsp.word_q <= word;
		end
	end

	// a line lives in at most one way, refills only go to a missing line
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
		else $error("lookup hit in more than one way");

	a_rotor_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(rotor))
		else $error("replacement rotor lost its one-hot state");

endmodule

`default_nettype wire

//--- design/icache_output.sv
`timescale 1ns/1ps
`default_nettype none

module icache_output (
	icache_rsp_if.out_side                                     rsp,
	input  wire  [icache_pkg::ways-1:0][icache_pkg::line_w-1:0] way_data,
	output logic [icache_pkg::inst_w-1:0]                       inst,
	output logic                                                inst_valid
);

	logic [icache_pkg::line_w-1:0] line_sel;

	// ------------------------------
	// way select or fill bypass
	// ------------------------------
	always_comb begin
		line_sel = '0;
		for (int w = 0; w < icache_pkg::ways; w++) begin
			if (rsp.hit_way_q[w]) begin
				line_sel = line_sel | way_data[w];
			end
		end
		if (rsp.hit_way_q == '0) begin
			line_sel = rsp.fill_line_q;    // last access missed
		end
	end

	// ------------------------------
	// word select
	// ------------------------------
	always_comb begin
		inst = line_sel[0 +: icache_pkg::inst_w];
		for (int i = 1; i < icache_pkg::words; i++) begin
			if (int'(rsp.word_q) == i) begin
				inst = line_sel[i*icache_pkg::inst_w +: icache_pkg::inst_w];
			end
		end
	end

	assign inst_valid = rsp.pending_q;

	// the lookup side must hand over a clean way select every cycle
	a_sel_onehot0: assert property (@(posedge rsp.clk) disable iff (rsp.rst)
		$onehot0(rsp.hit_way_q))
		else $error("response selects more than one way");

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input  wire                            clk,
	input  wire                            rst,

	// fetch side
	input  wire  [icache_pkg::addr_w-1:0]  fetch_addr,
	input  wire                            fetch_valid,
	input  wire                            flush,
	input  wire                            out_ready,
	output logic [icache_pkg::inst_w-1:0]  inst,
	output logic                           inst_valid,

	// memory side, line comes back in the same cycle
	output logic                           mem_req,
	output logic [icache_pkg::addr_w-1:0]  mem_addr,
	input  wire  [icache_pkg::line_w-1:0]  mem_line
);

	logic [icache_pkg::ways-1:0][icache_pkg::line_w-1:0] way_data;   // raw RAM outputs

	icache_rsp_if rsp_bus (
		.clk (clk),
		.rst (rst)
	);

	// ------------------------------
	// lookup and refill
	// ------------------------------
	icache_lookup u_lookup (
		.clk         (clk),
		.rst         (rst),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.flush       (flush),
		.out_ready   (out_ready),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_line    (mem_line),
		.rsp         (rsp_bus.lookup_side),
		.way_data    (way_data)
	);

	// ------------------------------
	// response to fetch stage
	// ------------------------------
	icache_output u_output (
		.rsp        (rsp_bus.out_side),
		.way_data   (way_data),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

	localparam int period   = 40;
	localparam int drive_dly = 2;
	localparam int rand_cycles = 2000;
	localparam int drain_max = 8;

	logic         clk;
	logic         rst;
	logic [31:0]  fetch_addr;
	logic         fetch_valid;
	logic         flush;
	logic         out_ready;
	logic [31:0]  inst;
	logic         inst_valid;
	logic         mem_req;
	logic [31:0]  mem_addr;
	logic [127:0] mem_line;

	// ------------------------------
	// model state
	// ------------------------------
	logic [21:0] m_tag [4][64];
	logic        m_valid [4][64];
	int          rot;                // victim way, index of the one-hot bit
	logic        exp_valid;
	logic [31:0] exp_inst;
	logic        held;               // out_ready was low at the last edge
	logic        last_req;           // mem_req seen in the last cycle
	logic [31:0] prev_inst;
	logic        prev_valid;
	logic [21:0] tag_pool [6];
	logic [31:0] rng_state;
	int          checks;
	int          errors;
	int          timeouts;

	icache_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.flush       (flush),
		.out_ready   (out_ready),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_line    (mem_line)
	);

	initial clk = 1'b0;
	always #(period / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_next();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// memory contents, a fixed mix of line address and word index
	function automatic logic [31:0] mem_word(input logic [31:0] line_addr, input int w);
		logic [31:0] x;
		x = line_addr ^ (32'h9e3779b9 * (w + 1));
		x = xorshift32(x);
		return xorshift32(x ^ 32'h5bd1e995);
	endfunction

	always_comb begin
		for (int w = 0; w < 4; w++) begin
			mem_line[w*32 +: 32] = mem_word({mem_addr[31:4], 4'b0000}, w);
		end
	end

	// small pool of lines on three sets, so ways get evicted
	function automatic logic [31:0] pick_addr();
		logic [31:0] r;
		logic [5:0]  st;
		r = rand_next();
		case (r[1:0])
			2'd0:    st = 6'd3;
			2'd1:    st = 6'd17;
			default: st = 6'd42;
		endcase
		return {tag_pool[int'(r[15:8]) % 6], st, r[5:4], 2'b00};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// one clock cycle: drive, check, model step
	// ------------------------------
	task automatic run_cycle(input logic [31:0] addr, input logic valid, input logic ready,
		input logic flsh);
		logic [21:0] tg;
		logic [5:0]  st;
		logic        acc;
		logic        ms;
		int          hw;
		fetch_addr  = addr;
		fetch_valid = valid;
		out_ready   = ready;
		flush       = flsh;
		tg  = addr[31:10];
		st  = addr[9:4];
		acc = valid && ready && !flsh;
		hw  = -1;
		for (int w = 0; w < 4; w++) begin
			if (m_valid[w][st] && m_tag[w][st] == tg) hw = w;
		end
		ms = acc && (hw < 0);

		@(negedge clk);    // inputs and outputs settled mid-cycle
		check_value(mem_req, ms, "mem_req");
		if (ms) check_value(mem_addr, {addr[31:4], 4'b0000}, "mem_addr");
		check_value(inst_valid, exp_valid, "inst_valid");
		if (exp_valid) check_value(inst, exp_inst, "inst");
		if (held) begin
			check_value(inst, prev_inst, "inst held on stall");
			check_value(inst_valid, prev_valid, "inst_valid held on stall");
		end
		prev_inst  = inst;
		prev_valid = inst_valid;
		last_req   = mem_req;

		@(posedge clk);
		#drive_dly;
		if (ms) begin
			m_tag[rot][st]   = tg;    // refill goes to the victim before the rotor steps
			m_valid[rot][st] = 1'b1;
		end
		held = !ready;
		if (ready) begin
			exp_valid = acc;
			if (acc) exp_inst = mem_word({addr[31:4], 4'b0000}, int'(addr[3:2]));
			if (!flsh) rot = (rot + 1) % 4;
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		int          n;
		checks    = 0;
		errors    = 0;
		timeouts  = 0;
		rng_state = 32'd77606;
		rst         = 1'b1;
		fetch_addr  = '0;
		fetch_valid = 1'b0;
		flush       = 1'b0;
		out_ready   = 1'b0;
		for (int k = 0; k < 6; k++) begin
			r = rand_next();
			tag_pool[k] = r[21:0];
		end
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < 64; s++) begin
				m_valid[w][s] = 1'b0;
				m_tag[w][s]   = '0;
			end
		end
		rot        = 0;
		exp_valid  = 1'b0;
		exp_inst   = '0;
		held       = 1'b0;
		last_req   = 1'b0;
		prev_inst  = '0;
		prev_valid = 1'b0;

		repeat (4) @(posedge clk);
		#drive_dly;
		rst = 1'b0;

		// idle after reset, nothing valid and no refill
		run_cycle(32'h0, 1'b0, 1'b1, 1'b0);
		run_cycle(32'h0, 1'b0, 1'b1, 1'b0);

		// ------------------------------
		// same line twice in a row
		// ------------------------------
		a = {22'h2a5a5, 6'd9, 4'h4};
		run_cycle(a, 1'b1, 1'b1, 1'b0);
		check_value(last_req, 1'b1, "first access to a fresh line misses");
		run_cycle(a + 32'd8, 1'b1, 1'b1, 1'b0);
		check_value(last_req, 1'b0, "second access to the same line hits");

		// flush drops the response in flight
		run_cycle(a, 1'b1, 1'b1, 1'b1);
		check_value(inst_valid, 1'b0, "inst_valid after flush");
		run_cycle(a + 32'd12, 1'b1, 1'b1, 1'b0);

		// ------------------------------
		// random traffic
		// ------------------------------
		for (int i = 0; i < rand_cycles; i++) begin
			r = rand_next();
			run_cycle(pick_addr(), r[2:0] != 3'd0, (int'(r[15:8]) % 5) != 0,
				r[20:16] == 5'd0);
		end

		a = {22'h15c3e, 6'd10, 4'h0};
		run_cycle(a, 1'b1, 1'b1, 1'b0);
		check_value(last_req, 1'b1, "late fresh line misses");
		run_cycle(a + 32'd4, 1'b1, 1'b1, 1'b0);
		check_value(last_req, 1'b0, "late repeat access hits");

		// drain the last response
		n = 0;
		while (inst_valid === 1'b1 && n < drain_max) begin
			run_cycle(32'h0, 1'b0, 1'b1, 1'b0);
			n++;
		end
		if (inst_valid === 1'b1) begin
			timeouts++;
			$display("timeout: inst_valid stayed high after the last request");
		end

		$display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/icache_pkg.sv
design/icache_rsp_if.sv
design/line_ram.sv
design/icache_lookup.sv
design/icache_output.sv
design/icache_top.sv
verif/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  # design sources in compile order
  - files:
      - design/icache_pkg.sv
      - design/icache_rsp_if.sv
      - design/line_ram.sv
      - design/icache_lookup.sv
      - design/icache_output.sv
      - design/icache_top.sv

  # testbench
  - target: test
    files:
      - verif/icache_tb.sv
